// ==== files.f ====
+incdir+source
source/mpmem_pkg.sv
source/bank_ram.sv
source/wr_steer.sv
source/rd_steer.sv
source/mpmem_top.sv
test/mpmem_sva.sv
test/mpmem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the mpmem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module mpmem_tb -f files.f -o mpmem_sim \
  || { echo "Build failed"; exit 1; }

./obj_dir/mpmem_sim | tee /dev/stderr | grep -q "All tests passed" \
  && echo "Simulation finished cleanly" \
  || { echo "Simulation reported a failure"; exit 1; }

// ==== test/mpmem_tb.sv ====
`include "mpmem_defs.svh"

module mpmem_tb;
  import mpmem_pkg::*;

  localparam int NUM_ADDR    = `MP_NUMVBNK * `MP_NUMVROW;
  localparam int FILL_CYCLES = (NUM_ADDR + `MP_NUMWRPT - 1) / `MP_NUMWRPT;
  localparam int RAND_CYCLES = 2000;
  localparam int DIR_PAIRS   = 16;
  localparam int DIR_CYCLES  = 2 * DIR_PAIRS;
  localparam int WATCHDOG    = (FILL_CYCLES + RAND_CYCLES + DIR_CYCLES + 20) * 4;

  // One port, one cycle
  typedef struct packed {
    logic  vld;
    logic  known;   // Address written before the request
    addr_t padr;
    word_t data;
  } exp_t;

  logic    clk;
  logic    rst;
  wr_req_t wr_req [`MP_NUMWRPT];
  rd_req_t rd_req [`MP_NUMRDPT];
  rd_rsp_t rd_rsp [`MP_NUMRDPT];

  wr_req_t wr_nxt [`MP_NUMWRPT];
  rd_req_t rd_nxt [`MP_NUMRDPT];
  bank_t   order  [`MP_NUMVBNK];
  word_t   model  [addr_t];
  exp_t    exp_q  [`MP_NUMRDPT][$];
  integer  seed    = 32'h562c_8abe;
  int      err_cnt = 0;

  mpmem_top dut (
    .clk    (clk),
    .rst    (rst),
    .wr_req (wr_req),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp)
  );

  always #2 clk = ~clk;

  task automatic report_failure();
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  // Random permutation of the bank numbers
  task automatic random_order();
    int    j;
    bank_t tmp;
    for (int b = 0; b < `MP_NUMVBNK; b++) begin
      order[b] = bank_t'(b);
    end
    for (int b = `MP_NUMVBNK - 1; b > 0; b--) begin
      j        = int'($unsigned($random(seed)) % (b + 1));
      tmp      = order[b];
      order[b] = order[j];
      order[j] = tmp;
    end
  endtask

  task automatic clear_requests();
    for (int p = 0; p < `MP_NUMWRPT; p++) begin
      wr_nxt[p] = '0;
    end
    for (int p = 0; p < `MP_NUMRDPT; p++) begin
      rd_nxt[p] = '0;
    end
  endtask

  // ############################
  // Checks and model update
  // ############################

  task automatic check_responses();
    exp_t e;
    for (int p = 0; p < `MP_NUMRDPT; p++) begin
      e = exp_q[p].pop_front();
      assert (rd_rsp[p].vld === e.vld) else begin
        err_cnt++;
        $display("ERR %0t rd_rsp[%0d].vld got %b exp %b", $time, p, rd_rsp[p].vld, e.vld);
        report_failure();
      end
      if (e.vld) begin
        assert (rd_rsp[p].padr === e.padr) else begin
          err_cnt++;
          $display("ERR %0t rd_rsp[%0d].padr got %h exp %h", $time, p, rd_rsp[p].padr, e.padr);
          report_failure();
        end
        if (e.known) begin
          assert (rd_rsp[p].data === e.data) else begin
            err_cnt++;
            $display("ERR %0t rd_rsp[%0d].data got %h exp %h", $time, p, rd_rsp[p].data,
                     e.data);
            report_failure();
          end
        end
      end
    end
  endtask

  task automatic apply_requests();
    exp_t  e;
    addr_t a;
    // Reads see the model before this edge's writes
    for (int p = 0; p < `MP_NUMRDPT; p++) begin
      a       = {rd_nxt[p].bank, rd_nxt[p].row};
      e.vld   = rd_nxt[p].vld;
      e.padr  = a;
      e.known = rd_nxt[p].vld && (model.exists(a) != 0);
      if (e.known) begin
        e.data = model[a];
      end else begin
        e.data = '0;
      end
      exp_q[p].push_back(e);
      rd_req[p] = rd_nxt[p];
    end
    for (int p = 0; p < `MP_NUMWRPT; p++) begin
      if (wr_nxt[p].vld) begin
        model[{wr_nxt[p].bank, wr_nxt[p].row}] = wr_nxt[p].data;
      end
      wr_req[p] = wr_nxt[p];
    end
  endtask

  task automatic run_cycle();
    @(negedge clk);
    check_responses();
    apply_requests();
  endtask

  // ############################
  // Stimulus
  // ############################

  initial begin
    int    k;
    addr_t a;
    int    wp;
    int    rp;

    clk = 1'b0;
    rst = 1'b1;
    clear_requests();
    wr_req = wr_nxt;
    rd_req = rd_nxt;
    // Reads issued under reset, one bank per port
    for (int p = 0; p < `MP_NUMRDPT; p++) begin
      rd_req[p].vld  = 1'b1;
      rd_req[p].bank = bank_t'(p);
      rd_req[p].row  = row_t'(p);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    rd_req = rd_nxt;
    for (int p = 0; p < `MP_NUMRDPT; p++) begin
      exp_q[p].push_back('0);   // Reset drops reads in flight
      exp_q[p].push_back('0);
    end

    // Fill, bank-interleaved so the ports never collide
    for (int c = 0; c < FILL_CYCLES; c++) begin
      clear_requests();
      for (int p = 0; p < `MP_NUMWRPT; p++) begin
        k = c * `MP_NUMWRPT + p;
        if (k < NUM_ADDR) begin
          wr_nxt[p].vld  = 1'b1;
          wr_nxt[p].bank = bank_t'(k % `MP_NUMVBNK);
          wr_nxt[p].row  = row_t'(k / `MP_NUMVBNK);
          wr_nxt[p].data = word_t'($random(seed));
        end
      end
      run_cycle();
    end

    for (int c = 0; c < RAND_CYCLES; c++) begin
      clear_requests();
      random_order();
      for (int p = 0; p < `MP_NUMWRPT; p++) begin
        wr_nxt[p].vld  = ($random(seed) & 3) != 0;
        wr_nxt[p].bank = order[p];
        wr_nxt[p].row  = row_t'($random(seed));
        wr_nxt[p].data = word_t'($random(seed));
      end
      random_order();
      for (int p = 0; p < `MP_NUMRDPT; p++) begin
        rd_nxt[p].vld  = ($random(seed) & 3) != 0;
        rd_nxt[p].bank = order[p];
        rd_nxt[p].row  = row_t'($random(seed));
      end
      run_cycle();
    end

    // Same address read and written at one edge
    for (int i = 0; i < DIR_PAIRS; i++) begin
      a  = addr_t'($random(seed));
      wp = i % `MP_NUMWRPT;
      rp = i % `MP_NUMRDPT;
      clear_requests();
      wr_nxt[wp].vld = 1'b1;
      {wr_nxt[wp].bank, wr_nxt[wp].row} = a;
      wr_nxt[wp].data = word_t'($random(seed));
      rd_nxt[rp].vld = 1'b1;
      {rd_nxt[rp].bank, rd_nxt[rp].row} = a;
      run_cycle();
      clear_requests();
      rp = (rp + 1) % `MP_NUMRDPT;
      rd_nxt[rp].vld = 1'b1;   // New value from here on
      {rd_nxt[rp].bank, rd_nxt[rp].row} = a;
      run_cycle();
    end

    clear_requests();
    repeat (2) run_cycle();

    if (err_cnt == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      report_failure();
    end
  end

  initial begin
    #(WATCHDOG);
    $display("Watchdog expired after %0d time units with tests still running", WATCHDOG);
    report_failure();
  end

endmodule

// ==== test/mpmem_sva.sv ====
`include "mpmem_defs.svh"

module mpmem_sva (
  input logic               clk,
  input logic               rst,
  input mpmem_pkg::wr_req_t wr_req [`MP_NUMWRPT],
  input mpmem_pkg::rd_req_t rd_req [`MP_NUMRDPT],
  input mpmem_pkg::rd_rsp_t rd_rsp [`MP_NUMRDPT]
);
  import mpmem_pkg::*;

  // ############################
  // Bank conflict contract
  // ############################

  for (genvar i = 0; i < `MP_NUMWRPT; i++) begin : g_wr_a
    for (genvar j = i + 1; j < `MP_NUMWRPT; j++) begin : g_wr_b
      a_wr_bank: assert property (@(posedge clk) disable iff (rst)
        !(wr_req[i].vld && wr_req[j].vld && wr_req[i].bank == wr_req[j].bank))
        else $error("Write ports %0d and %0d target one bank", i, j);
    end
  end

  for (genvar i = 0; i < `MP_NUMRDPT; i++) begin : g_rd_a
    for (genvar j = i + 1; j < `MP_NUMRDPT; j++) begin : g_rd_b
      a_rd_bank: assert property (@(posedge clk) disable iff (rst)
        !(rd_req[i].vld && rd_req[j].vld && rd_req[i].bank == rd_req[j].bank))
        else $error("Read ports %0d and %0d target one bank", i, j);
    end
  end

  // ############################
  // Response timing
  // ############################

  // Reset drops whatever was in flight
  for (genvar p = 0; p < `MP_NUMRDPT; p++) begin : g_rsp
    a_rsp_vld: assert property (@(posedge clk) disable iff (rst)
      rd_rsp[p].vld == ($past(rd_req[p].vld, 2) && !$past(rst, 1) && !$past(rst, 2)))
      else $error("rd_rsp[%0d].vld out of step with its request", p);
  end

endmodule

bind mpmem_top mpmem_sva u_sva (
  .clk    (clk),
  .rst    (rst),
  .wr_req (wr_req),
  .rd_req (rd_req),
  .rd_rsp (rd_rsp)
);

// ==== source/mpmem_top.sv ====
`include "mpmem_defs.svh"

module mpmem_top (
  input  logic               clk,
  input  logic               rst,
  input  mpmem_pkg::wr_req_t wr_req [`MP_NUMWRPT],
  input  mpmem_pkg::rd_req_t rd_req [`MP_NUMRDPT],
  output mpmem_pkg::rd_rsp_t rd_rsp [`MP_NUMRDPT]
);
  import mpmem_pkg::*;

  bank_wr_t bank_wr   [`MP_NUMVBNK];
  bank_rd_t bank_rd   [`MP_NUMVBNK];
  word_t    bank_dout [`MP_NUMVBNK];

  // ############################
  // Write side
  // ############################

  wr_steer u_wr_steer (
    .wr_req  (wr_req),
    .bank_wr (bank_wr)
  );

  // ############################
  // Read side
  // ############################

  rd_steer u_rd_steer (
    .clk       (clk),
    .rst       (rst),
    .rd_req    (rd_req),
    .bank_rd   (bank_rd),
    .bank_dout (bank_dout),
    .rd_rsp    (rd_rsp)
  );

  // ############################
  // Banks
  // ############################

  for (genvar b = 0; b < `MP_NUMVBNK; b++) begin : g_bank
    bank_ram u_bank (
      .clk  (clk),
      .wr   (bank_wr[b]),
      .rd   (bank_rd[b]),
      .dout (bank_dout[b])
    );
  end

endmodule

// ==== source/rd_steer.sv ====
`include "mpmem_defs.svh"

module rd_steer (
  input  logic                clk,
  input  logic                rst,
  input  mpmem_pkg::rd_req_t  rd_req    [`MP_NUMRDPT],
  output mpmem_pkg::bank_rd_t bank_rd   [`MP_NUMVBNK],
  input  mpmem_pkg::word_t    bank_dout [`MP_NUMVBNK],
  output mpmem_pkg::rd_rsp_t  rd_rsp    [`MP_NUMRDPT]
);
  import mpmem_pkg::*;

  localparam int LAST = `MP_SRAM_DELAY - 1;

  // One slot of the per-port return pipeline
  typedef struct packed {
    logic  vld;
    bank_t bank;   // Selects the returning bank
    addr_t padr;
  } rd_stage_t;

  logic [`MP_NUMRDPT-1:0] hit [`MP_NUMVBNK];
  rd_stage_t rd_new  [`MP_NUMRDPT];
  rd_stage_t rd_pipe [`MP_NUMRDPT][`MP_SRAM_DELAY];

  // ############################
  // Request decode
  // ############################

  always_comb begin
    for (int b = 0; b < `MP_NUMVBNK; b++) begin
      for (int p = 0; p < `MP_NUMRDPT; p++) begin
        hit[b][p] = rd_req[p].vld && (rd_req[p].bank == bank_t'(b));
      end
    end
  end

  always_comb begin
    for (int b = 0; b < `MP_NUMVBNK; b++) begin
      bank_rd[b].re  = |hit[b];
      bank_rd[b].row = '0;
      for (int p = 0; p < `MP_NUMRDPT; p++) begin
        if (hit[b][p]) begin
          bank_rd[b].row = bank_rd[b].row | rd_req[p].row;
        end
      end
    end
  end

  // ############################
  // Return pipeline
  // ############################

  always_comb begin
    for (int p = 0; p < `MP_NUMRDPT; p++) begin
      rd_new[p].vld  = rd_req[p].vld;
      rd_new[p].bank = rd_req[p].bank;
      rd_new[p].padr = {rd_req[p].bank, rd_req[p].row};
    end
  end

  // Same depth as the bank read path
  always_ff @(posedge clk) begin
    for (int p = 0; p < `MP_NUMRDPT; p++) begin
      rd_pipe[p][0] <= rd_new[p];
      for (int s = 1; s < `MP_SRAM_DELAY; s++) begin
        rd_pipe[p][s] <= rd_pipe[p][s-1];
      end
      if (rst) begin
        for (int s = 0; s < `MP_SRAM_DELAY; s++) begin
          rd_pipe[p][s].vld <= 1'b0;   // Payload keeps its value
        end
      end
    end
  end

  // ############################
  // Response
  // ############################

  always_comb begin
    for (int p = 0; p < `MP_NUMRDPT; p++) begin
      rd_rsp[p].vld  = rd_pipe[p][LAST].vld;
      rd_rsp[p].data = bank_dout[rd_pipe[p][LAST].bank];
      rd_rsp[p].padr = rd_pipe[p][LAST].padr;
    end
  end

endmodule

// ==== source/wr_steer.sv ====
`include "mpmem_defs.svh"

module wr_steer (
  input  mpmem_pkg::wr_req_t  wr_req  [`MP_NUMWRPT],
  output mpmem_pkg::bank_wr_t bank_wr [`MP_NUMVBNK]
);
  import mpmem_pkg::*;

  logic [`MP_NUMWRPT-1:0] hit [`MP_NUMVBNK];   // Port p targets bank b

  // ############################
  // Port to bank match
  // ############################

  always_comb begin
    for (int b = 0; b < `MP_NUMVBNK; b++) begin
      for (int p = 0; p < `MP_NUMWRPT; p++) begin
        hit[b][p] = wr_req[p].vld && (wr_req[p].bank == bank_t'(b));
      end
    end
  end

  // ############################
  // Bank write ports
  // ############################

  // AND-OR select, at most one hit per bank by contract
  always_comb begin
    for (int b = 0; b < `MP_NUMVBNK; b++) begin
      bank_wr[b].we   = |hit[b];
      bank_wr[b].row  = '0;
      bank_wr[b].data = '0;
      for (int p = 0; p < `MP_NUMWRPT; p++) begin
        if (hit[b][p]) begin
          bank_wr[b].row  = bank_wr[b].row | wr_req[p].row;
          bank_wr[b].data = bank_wr[b].data | wr_req[p].data;
        end
      end
    end
  end

endmodule

// ==== source/bank_ram.sv ====
`include "mpmem_defs.svh"

module bank_ram (
  input  logic                clk,
  input  mpmem_pkg::bank_wr_t wr,
  input  mpmem_pkg::bank_rd_t rd,
  output mpmem_pkg::word_t    dout
);
  import mpmem_pkg::*;

  localparam int LAST = `MP_SRAM_DELAY - 1;

  word_t mem     [`MP_NUMVROW];
  word_t rd_pipe [`MP_SRAM_DELAY];

  // ############################
  // Storage
  // ############################

  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr.row] <= wr.data;
    end
  end

  // ############################
  // Read path
  // ############################

  // First stage samples the array before this edge's write lands
  always_ff @(posedge clk) begin
    if (rd.re) begin
      rd_pipe[0] <= mem[rd.row];
    end
  end

  // Output register and any further delay
  always_ff @(posedge clk) begin
    for (int s = 1; s < `MP_SRAM_DELAY; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];
    end
  end

  assign dout = rd_pipe[LAST];

endmodule

// ==== source/mpmem_pkg.sv ====
`include "mpmem_defs.svh"

package mpmem_pkg;

  // ############################
  // Basic fields
  // ############################

  typedef logic [`MP_WIDTH-1:0]   word_t;
  typedef logic [`MP_BITVBNK-1:0] bank_t;
  typedef logic [`MP_BITVROW-1:0] row_t;
  typedef logic [`MP_BITADDR-1:0] addr_t;   // {bank, row}

  // ############################
  // Port side
  // ############################

  typedef struct packed {
    logic  vld;
    bank_t bank;
    row_t  row;
    word_t data;
  } wr_req_t;

  typedef struct packed {
    logic  vld;
    bank_t bank;
    row_t  row;
  } rd_req_t;

  // Returned SRAM_DELAY cycles after the request
  typedef struct packed {
    logic  vld;
    word_t data;
    addr_t padr;
  } rd_rsp_t;

  // ############################
  // Bank side
  // ############################

  typedef struct packed {
    logic  we;
    row_t  row;
    word_t data;
  } bank_wr_t;

  typedef struct packed {
    logic re;
    row_t row;
  } bank_rd_t;

endpackage

// ==== source/mpmem_defs.svh ====
`ifndef MPMEM_DEFS_SVH
`define MPMEM_DEFS_SVH

// ############################
// Memory geometry
// ############################

`define MP_WIDTH      16   // Bits per word
`define MP_NUMRDPT    2    // Read ports
`define MP_NUMWRPT    3    // Write ports

// Banked array
`define MP_NUMVBNK    8
`define MP_BITVBNK    3
`define MP_NUMVROW    16   // Rows in each bank
`define MP_BITVROW    4

// Bank number on top, row below
`define MP_BITADDR    7

// ############################
// Timing
// ############################

`define MP_SRAM_DELAY 2    // Bank read enable to data

`endif
